/* tcip_cfg.svh */
`ifndef TCIP_CFG_SVH
`define TCIP_CFG_SVH

// Bus widths
`define TCIP_DATA_W        32
`define TCIP_ADDR_W        32
`define TCIP_LOCAL_ADDR_W  16

// Core timer window on addr[31:8]
`define TCIP_CORETIM_BASE  24'hE000E0
// Hole inside the timer window, matched on addr[31:4]
`define TCIP_CORETIM_EXCL  28'hE000E00

// Interrupt controller window on addr[31:12]
`define TCIP_VIC_BASE      20'hE000E
// Holes in the VIC window, matched on addr[31:8]
`define TCIP_VIC_EXCL1     24'hE000E0
`define TCIP_VIC_EXCL2     24'hE000ED
`define TCIP_VIC_EXCL3     24'hE000EE
`define TCIP_VIC_EXCL4     24'hE000EF

// Debug image window on addr[31:12]
`define TCIP_HAD_IMG_BASE  20'hE0011

`endif

/* tcip_pkg.sv */
`include "tcip_cfg.svh"

package tcip_pkg;

  // Request content from the data bus master
  typedef struct packed {
    logic [`TCIP_ADDR_W-1:0] addr;
    logic [1:0]              size;
    logic                    write;
    logic [`TCIP_DATA_W-1:0] wdata;
  } dbus_req_t;

  // Response from a single peripheral
  typedef struct packed {
    logic                    cmplt;
    logic [`TCIP_DATA_W-1:0] rdata;
  } periph_rsp_t;

  // Outstanding target of the bridge
  // TGT_IDLE also covers the dummy access, which never holds a select
  typedef enum logic [1:0] {
    TGT_IDLE    = 2'd0,
    TGT_CORETIM = 2'd1,
    TGT_VIC     = 2'd2,
    TGT_HAD_IMG = 2'd3
  } tcip_target_e;

endpackage

/* tcip_priv_check.sv */
module tcip_priv_check (
  input  logic sel_cpuclk,
  input  logic cpurst_b,
  input  logic req,
  input  logic busy,
  input  logic acc_deny,
  input  logic chk_fail,
  input  logic supv_mode,
  input  logic dbgon,
  output logic grnt,
  output logic take,
  output logic route,
  output logic acc_err
);

  logic priv;

  // Grant whenever no peripheral is still working
  assign grnt = req && !busy;

  // Denied or failed requests are handled by the master
  assign take = grnt && !acc_deny && !chk_fail;

  // Debug mode overrides user mode
  assign priv = supv_mode || dbgon;

  assign route = take && priv;

  // One cycle error pulse after an unprivileged take
  always_ff @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      acc_err <= 1'b0;
    else if (take)
      acc_err <= !priv;
    else if (acc_err)
      acc_err <= 1'b0;
  end

  // The master does not reissue in the error completion cycle
  a_acc_err_pulse: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    acc_err |=> !acc_err)
    else $error("acc_err held for more than one cycle");

endmodule

/* tcip_addr_route.sv */
`include "tcip_cfg.svh"

module tcip_addr_route (
  input  logic                          sel_cpuclk,
  input  logic                          cpurst_b,
  input  logic                          route,
  input  tcip_pkg::dbus_req_t           dbus,
  input  logic                          coretim_cmplt,
  input  logic                          vic_cmplt,
  input  logic                          had_img_cmplt,
  output logic                          coretim_sel,
  output logic                          vic_sel,
  output logic                          had_img_sel,
  output logic [1:0]                    vic_size,
  output logic [`TCIP_LOCAL_ADDR_W-1:0] local_addr,
  output logic                          write,
  output logic                          busy,
  output logic                          dummy_cmplt
);

  logic                   coretim_hit;
  logic                   vic_hit;
  logic                   had_img_hit;
  logic                   cur_cmplt;
  tcip_pkg::tcip_target_e dec_tgt;
  tcip_pkg::tcip_target_e cur_tgt;

  // Window decode
  assign coretim_hit = (dbus.addr[31:8] == `TCIP_CORETIM_BASE)
                    && (dbus.addr[31:4] != `TCIP_CORETIM_EXCL);

  assign vic_hit = (dbus.addr[31:12] == `TCIP_VIC_BASE)
                && (dbus.addr[31:8] != `TCIP_VIC_EXCL1)
                && (dbus.addr[31:8] != `TCIP_VIC_EXCL2)
                && (dbus.addr[31:8] != `TCIP_VIC_EXCL3)
                && (dbus.addr[31:8] != `TCIP_VIC_EXCL4);

  assign had_img_hit = (dbus.addr[31:12] == `TCIP_HAD_IMG_BASE);

  // Windows are disjoint so order does not matter
  always_comb
  begin
    if (coretim_hit)
      dec_tgt = tcip_pkg::TGT_CORETIM;
    else if (vic_hit)
      dec_tgt = tcip_pkg::TGT_VIC;
    else if (had_img_hit)
      dec_tgt = tcip_pkg::TGT_HAD_IMG;
    else
      dec_tgt = tcip_pkg::TGT_IDLE;
  end

  // Completion of the peripheral that owns the bus
  always_comb
  begin
    case (cur_tgt)
      tcip_pkg::TGT_CORETIM: cur_cmplt = coretim_cmplt;
      tcip_pkg::TGT_VIC:     cur_cmplt = vic_cmplt;
      tcip_pkg::TGT_HAD_IMG: cur_cmplt = had_img_cmplt;
      default:               cur_cmplt = 1'b0;
    endcase
  end

  // Route may land in the cmplt cycle and take priority
  always_ff @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_tgt <= tcip_pkg::TGT_IDLE;
    else if (route)
      cur_tgt <= dec_tgt;
    else if (cur_cmplt)
      cur_tgt <= tcip_pkg::TGT_IDLE;
  end

  assign coretim_sel = (cur_tgt == tcip_pkg::TGT_CORETIM);
  assign vic_sel     = (cur_tgt == tcip_pkg::TGT_VIC);
  assign had_img_sel = (cur_tgt == tcip_pkg::TGT_HAD_IMG);

  assign busy = (cur_tgt != tcip_pkg::TGT_IDLE) && !cur_cmplt;

  // Unmapped address completes on its own
  always_ff @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dummy_cmplt <= 1'b0;
    else
      dummy_cmplt <= route && (dec_tgt == tcip_pkg::TGT_IDLE);
  end

  // Direction also qualifies data_vld
  always_ff @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      write <= 1'b0;
    else if (route)
      write <= dbus.write;
  end

  always_ff @(posedge sel_cpuclk)
  begin
    if (route)
    begin
      vic_size   <= dbus.size;
      local_addr <= dbus.addr[`TCIP_LOCAL_ADDR_W-1:0];
    end
  end

  // Grant in the checker must keep new requests away while busy
  a_route_idle: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    route |-> !busy)
    else $error("route taken while a peripheral is busy");

  // A peripheral answers only while it is selected
  a_cmplt_selected: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    ({coretim_cmplt, vic_cmplt, had_img_cmplt}
     & ~{coretim_sel, vic_sel, had_img_sel}) == 3'b000)
    else $error("peripheral completion without its select");

endmodule

/* tcip_resp_merge.sv */
`include "tcip_cfg.svh"

module tcip_resp_merge (
  input  logic                     be_v2,
  input  logic                     acc_err_in,
  input  logic                     dummy_cmplt,
  input  logic                     write,
  input  tcip_pkg::periph_rsp_t    coretim_rsp,
  input  tcip_pkg::periph_rsp_t    vic_rsp,
  input  tcip_pkg::periph_rsp_t    had_img_rsp,
  input  logic [`TCIP_DATA_W-1:0]  wdata_in,
  output logic                     trans_cmplt,
  output logic                     data_vld,
  output logic                     acc_err,
  output logic [`TCIP_DATA_W-1:0]  rdata,
  output logic [`TCIP_DATA_W-1:0]  wdata_out
);

  logic                    periph_cmplt;
  logic [`TCIP_DATA_W-1:0] rd_mux;

  // Byte order reversal for big endian mode
  function automatic logic [`TCIP_DATA_W-1:0] byte_rev(input logic [`TCIP_DATA_W-1:0] d);
    logic [`TCIP_DATA_W-1:0] r;
    for (int i = 0; i < `TCIP_DATA_W / 8; i++)
      r[8*i +: 8] = d[`TCIP_DATA_W-8-8*i +: 8];
    return r;
  endfunction

  assign periph_cmplt = coretim_rsp.cmplt || vic_rsp.cmplt || had_img_rsp.cmplt;

  assign trans_cmplt = periph_cmplt || dummy_cmplt || acc_err_in;

  // Errors never carry data
  assign data_vld = (periph_cmplt || dummy_cmplt) && !write;

  assign acc_err = acc_err_in;

  // AND-OR select, dummy access reads back zero
  assign rd_mux = ({`TCIP_DATA_W{coretim_rsp.cmplt}} & coretim_rsp.rdata)
                | ({`TCIP_DATA_W{vic_rsp.cmplt}}     & vic_rsp.rdata)
                | ({`TCIP_DATA_W{had_img_rsp.cmplt}} & had_img_rsp.rdata);

  assign rdata     = be_v2 ? byte_rev(rd_mux) : rd_mux;
  assign wdata_out = be_v2 ? byte_rev(wdata_in) : wdata_in;

  // Only the selected peripheral may answer
  always_comb
  begin
    a_cmplt_onehot: assert final ($onehot0({coretim_rsp.cmplt, vic_rsp.cmplt,
                                            had_img_rsp.cmplt}))
      else $error("two peripheral completions in one cycle");
  end

endmodule

/* tcip_bus_if.sv */
`include "tcip_cfg.svh"

module tcip_bus_if (
  input  logic                          sel_cpuclk,
  input  logic                          cpurst_b,
  input  logic                          req,
  input  tcip_pkg::dbus_req_t           dbus,
  input  logic                          supv_mode,
  input  logic                          dbgon,
  input  logic                          acc_deny,
  input  logic                          chk_fail,
  input  logic                          be_v2,
  input  tcip_pkg::periph_rsp_t         coretim_rsp,
  input  tcip_pkg::periph_rsp_t         vic_rsp,
  input  tcip_pkg::periph_rsp_t         had_img_rsp,
  output logic                          grnt,
  output logic                          trans_cmplt,
  output logic                          data_vld,
  output logic                          acc_err,
  output logic [`TCIP_DATA_W-1:0]       rdata,
  output logic                          coretim_sel,
  output logic                          vic_sel,
  output logic                          had_img_sel,
  output logic [1:0]                    vic_size,
  output logic [`TCIP_LOCAL_ADDR_W-1:0] local_addr,
  output logic                          write,
  output logic [`TCIP_DATA_W-1:0]       wdata
);

  logic busy;
  logic route;
  logic priv_err;
  logic dummy_cmplt;

  tcip_priv_check u_priv_check (
    .sel_cpuclk (sel_cpuclk),
    .cpurst_b   (cpurst_b),
    .req        (req),
    .busy       (busy),
    .acc_deny   (acc_deny),
    .chk_fail   (chk_fail),
    .supv_mode  (supv_mode),
    .dbgon      (dbgon),
    .grnt       (grnt),
    .take       (),
    .route      (route),
    .acc_err    (priv_err)
  );

  tcip_addr_route u_addr_route (
    .sel_cpuclk    (sel_cpuclk),
    .cpurst_b      (cpurst_b),
    .route         (route),
    .dbus          (dbus),
    .coretim_cmplt (coretim_rsp.cmplt),
    .vic_cmplt     (vic_rsp.cmplt),
    .had_img_cmplt (had_img_rsp.cmplt),
    .coretim_sel   (coretim_sel),
    .vic_sel       (vic_sel),
    .had_img_sel   (had_img_sel),
    .vic_size      (vic_size),
    .local_addr    (local_addr),
    .write         (write),
    .busy          (busy),
    .dummy_cmplt   (dummy_cmplt)
  );

  // Write data goes out straight from the request
  tcip_resp_merge u_resp_merge (
    .be_v2       (be_v2),
    .acc_err_in  (priv_err),
    .dummy_cmplt (dummy_cmplt),
    .write       (write),
    .coretim_rsp (coretim_rsp),
    .vic_rsp     (vic_rsp),
    .had_img_rsp (had_img_rsp),
    .wdata_in    (dbus.wdata),
    .trans_cmplt (trans_cmplt),
    .data_vld    (data_vld),
    .acc_err     (acc_err),
    .rdata       (rdata),
    .wdata_out   (wdata)
  );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
  output logic sel_cpuclk,
  output logic cpurst_b
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 3;

  logic clk   = 1'b0;
  logic rst_n = 1'b0;

  assign sel_cpuclk = clk;
  assign cpurst_b   = rst_n;

  always #HALF_PERIOD clk = ~clk;

  // Release on a rising edge like the other inputs
  initial
  begin
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tb_tcip.sv */
`include "tcip_cfg.svh"

module tb_tcip;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          TIMEOUT = 50;
  localparam logic [31:0] SEED    = 32'd90374;

  logic                          sel_cpuclk;
  logic                          cpurst_b;
  logic                          req       = 1'b0;
  tcip_pkg::dbus_req_t           dbus      = '0;
  logic                          supv_mode = 1'b0;
  logic                          dbgon     = 1'b0;
  logic                          acc_deny  = 1'b0;
  logic                          chk_fail  = 1'b0;
  logic                          be_v2     = 1'b0;
  tcip_pkg::periph_rsp_t         rsp [3]   = '{default: '0};
  logic                          grnt;
  logic                          trans_cmplt;
  logic                          data_vld;
  logic                          acc_err;
  logic [`TCIP_DATA_W-1:0]       rdata;
  logic                          coretim_sel;
  logic                          vic_sel;
  logic                          had_img_sel;
  logic [1:0]                    vic_size;
  logic [`TCIP_LOCAL_ADDR_W-1:0] local_addr;
  logic                          write;
  logic [`TCIP_DATA_W-1:0]       wdata;

  // Reference state, built from the bridge rules
  tcip_pkg::tcip_target_e        exp_tgt;
  logic                          exp_err;
  logic                          exp_dummy;
  logic                          cap_write;
  logic [1:0]                    cap_size;
  logic [`TCIP_LOCAL_ADDR_W-1:0] cap_addr;
  logic                          tgt_cmplt;
  logic                          any_cmplt;
  logic                          exp_grnt;
  logic                          exp_take;
  logic                          exp_priv;
  logic                          exp_cmplt;
  logic                          exp_vld;
  logic [31:0]                   exp_rdata;
  logic [31:0]                   exp_wdata;
  logic [2:0]                    sel_vec;

  // Peripheral models
  logic [2:0]                    armed;
  logic [2:0]                    cnt [3];
  logic [31:0]                   rec_rdata = '0;
  logic [31:0]                   model_lcg = SEED;
  logic [31:0]                   stim_lcg  = SEED;

  int err_cnt    = 0;
  int pass_tests = 0;
  int fail_tests = 0;

  tb_clk_gen u_clk_gen (
    .sel_cpuclk (sel_cpuclk),
    .cpurst_b   (cpurst_b)
  );

  tcip_bus_if uut (
    .sel_cpuclk  (sel_cpuclk),
    .cpurst_b    (cpurst_b),
    .req         (req),
    .dbus        (dbus),
    .supv_mode   (supv_mode),
    .dbgon       (dbgon),
    .acc_deny    (acc_deny),
    .chk_fail    (chk_fail),
    .be_v2       (be_v2),
    .coretim_rsp (rsp[0]),
    .vic_rsp     (rsp[1]),
    .had_img_rsp (rsp[2]),
    .grnt        (grnt),
    .trans_cmplt (trans_cmplt),
    .data_vld    (data_vld),
    .acc_err     (acc_err),
    .rdata       (rdata),
    .coretim_sel (coretim_sel),
    .vic_sel     (vic_sel),
    .had_img_sel (had_img_sel),
    .vic_size    (vic_size),
    .local_addr  (local_addr),
    .write       (write),
    .wdata       (wdata)
  );

  function automatic logic [31:0] lcg_step(inout logic [31:0] st);
    st = st * 32'd1103515245 + 32'd12345;
    return {st[15:0], st[31:16]};
  endfunction

  function automatic logic [31:0] rnd();
    return lcg_step(stim_lcg);
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  // Windows first, then the holes cut out of them
  function automatic tcip_pkg::tcip_target_e target_of(input logic [31:0] a);
    if (a[31:8] == `TCIP_CORETIM_BASE && a[31:4] != `TCIP_CORETIM_EXCL)
      return tcip_pkg::TGT_CORETIM;
    if (a[31:12] == `TCIP_VIC_BASE && a[31:8] != `TCIP_VIC_EXCL1
        && a[31:8] != `TCIP_VIC_EXCL2 && a[31:8] != `TCIP_VIC_EXCL3
        && a[31:8] != `TCIP_VIC_EXCL4)
      return tcip_pkg::TGT_VIC;
    if (a[31:12] == `TCIP_HAD_IMG_BASE)
      return tcip_pkg::TGT_HAD_IMG;
    return tcip_pkg::TGT_IDLE;
  endfunction

  function automatic logic [2:0] sel_code(input tcip_pkg::tcip_target_e t);
    case (t)
      tcip_pkg::TGT_CORETIM: return 3'b001;
      tcip_pkg::TGT_VIC:     return 3'b010;
      tcip_pkg::TGT_HAD_IMG: return 3'b100;
      default:               return 3'b000;
    endcase
  endfunction

  function automatic logic [31:0] mapped_addr(input logic [31:0] r);
    logic [3:0] blk;
    blk = (r[11:8] == 4'h0 || r[11:8] > 4'hC) ? 4'h3 : r[11:8];
    case (r[31:30])
      2'd0:    return {`TCIP_CORETIM_BASE, (r[7:4] == 4'h0) ? 4'h8 : r[7:4], r[3:0]};
      2'd1:    return {`TCIP_VIC_BASE, blk, r[7:0]};
      default: return {`TCIP_HAD_IMG_BASE, r[11:0]};
    endcase
  endfunction

  // Holes and addresses far from every window
  function automatic logic [31:0] unmapped_addr(input logic [31:0] r);
    case (r[31:30])
      2'd0:    return {`TCIP_CORETIM_EXCL, r[3:0]};
      2'd1:    return {r[9] ? `TCIP_VIC_EXCL3 : `TCIP_VIC_EXCL4, r[7:0]};
      2'd2:    return {`TCIP_VIC_EXCL2, r[7:0]};
      default: return {4'h2, r[27:0]};
    endcase
  endfunction

  function automatic logic [31:0] any_addr(input logic [31:0] r);
    return r[5] ? mapped_addr(r) : unmapped_addr(r);
  endfunction

  assign sel_vec   = {had_img_sel, vic_sel, coretim_sel};
  assign any_cmplt = rsp[0].cmplt || rsp[1].cmplt || rsp[2].cmplt;

  always_comb
  begin
    case (exp_tgt)
      tcip_pkg::TGT_CORETIM: tgt_cmplt = rsp[0].cmplt;
      tcip_pkg::TGT_VIC:     tgt_cmplt = rsp[1].cmplt;
      tcip_pkg::TGT_HAD_IMG: tgt_cmplt = rsp[2].cmplt;
      default:               tgt_cmplt = 1'b0;
    endcase
  end

  assign exp_grnt  = req && !(exp_tgt != tcip_pkg::TGT_IDLE && !tgt_cmplt);
  assign exp_take  = exp_grnt && !acc_deny && !chk_fail;
  assign exp_priv  = supv_mode || dbgon;
  assign exp_cmplt = exp_err || exp_dummy || any_cmplt;
  assign exp_vld   = (exp_dummy || any_cmplt) && !cap_write;
  assign exp_rdata = be_v2 ? swap_bytes(any_cmplt ? rec_rdata : 32'h0)
                           : (any_cmplt ? rec_rdata : 32'h0);
  assign exp_wdata = be_v2 ? swap_bytes(dbus.wdata) : dbus.wdata;

  always @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      exp_tgt   <= tcip_pkg::TGT_IDLE;
      exp_err   <= 1'b0;
      exp_dummy <= 1'b0;
      cap_write <= 1'b0;
      cap_size  <= 2'b00;
      cap_addr  <= '0;
    end
    else
    begin
      exp_err   <= exp_take && !exp_priv;
      exp_dummy <= exp_take && exp_priv && (target_of(dbus.addr) == tcip_pkg::TGT_IDLE);
      if (exp_take && exp_priv)
      begin
        exp_tgt   <= target_of(dbus.addr);
        cap_write <= dbus.write;
        cap_size  <= dbus.size;
        cap_addr  <= dbus.addr[`TCIP_LOCAL_ADDR_W-1:0];
      end
      else if (tgt_cmplt)
        exp_tgt <= tcip_pkg::TGT_IDLE;
    end
  end

  // Each model waits 0 to 5 cycles once selected, then answers for one cycle
  always @(posedge sel_cpuclk or negedge cpurst_b)
  begin
    logic [31:0] r;
    if (!cpurst_b)
    begin
      armed <= 3'b000;
      for (int i = 0; i < 3; i++)
      begin
        cnt[i]       <= 3'd0;
        rsp[i].cmplt <= 1'b0;
      end
    end
    else
    begin
      for (int i = 0; i < 3; i++)
      begin
        rsp[i].cmplt <= 1'b0;
        if (sel_vec[i] && !armed[i] && !rsp[i].cmplt)
        begin
          r = lcg_step(model_lcg);
          armed[i] <= 1'b1;
          cnt[i]   <= 3'(r % 32'd6);
        end
        else if (armed[i])
        begin
          if (cnt[i] == 3'd0)
          begin
            r = lcg_step(model_lcg);
            rsp[i].cmplt <= 1'b1;
            rsp[i].rdata <= r;
            rec_rdata    <= r;
            armed[i]     <= 1'b0;
          end
          else
            cnt[i] <= cnt[i] - 3'd1;
        end
      end
    end
  end

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    err_cnt++;
    $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
  endtask

  a_grnt: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    grnt == exp_grnt)
    else report_value("grnt", 32'($sampled(exp_grnt)), 32'($sampled(grnt)));

  a_sel: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    sel_vec == sel_code(exp_tgt))
    else report_value("sel", 32'(sel_code($sampled(exp_tgt))), 32'($sampled(sel_vec)));

  a_err: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    acc_err == exp_err)
    else report_value("acc_err", 32'($sampled(exp_err)), 32'($sampled(acc_err)));

  a_cmplt: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    trans_cmplt == exp_cmplt)
    else report_value("trans_cmplt", 32'($sampled(exp_cmplt)), 32'($sampled(trans_cmplt)));

  a_vld: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    data_vld == exp_vld)
    else report_value("data_vld", 32'($sampled(exp_vld)), 32'($sampled(data_vld)));

  a_rdata: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    data_vld |-> rdata == exp_rdata)
    else report_value("rdata", $sampled(exp_rdata), $sampled(rdata));

  a_wdata: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    wdata == exp_wdata)
    else report_value("wdata", $sampled(exp_wdata), $sampled(wdata));

  a_addr: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    (|sel_vec) |-> local_addr == cap_addr)
    else report_value("local_addr", 32'($sampled(cap_addr)), 32'($sampled(local_addr)));

  a_write: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    (|sel_vec) |-> write == cap_write)
    else report_value("write", 32'($sampled(cap_write)), 32'($sampled(write)));

  a_size: assert property (@(posedge sel_cpuclk) disable iff (!cpurst_b)
    vic_sel |-> vic_size == cap_size)
    else report_value("vic_size", 32'($sampled(cap_size)), 32'($sampled(vic_size)));

  task automatic wait_reset();
    for (int n = 0; n < TIMEOUT && !cpurst_b; n++)
    begin
      @(posedge sel_cpuclk);
    end
    if (!cpurst_b)
    begin
      err_cnt++;
      $display("Timeout: reset was never released");
    end
  endtask

  task automatic drive_req(input logic [31:0] addr, input logic wr, input logic sv,
                           input logic dbg, input logic deny, input logic fail);
    logic [31:0] r;
    r = rnd();
    req        <= 1'b1;
    dbus.addr  <= addr;
    dbus.size  <= r[1:0];
    dbus.write <= wr;
    dbus.wdata <= rnd();
    supv_mode  <= sv;
    dbgon      <= dbg;
    acc_deny   <= deny;
    chk_fail   <= fail;
    be_v2      <= r[2];
  endtask

  task automatic wait_grant(output logic ok);
    ok = 1'b0;
    for (int n = 0; n < TIMEOUT && !ok; n++)
    begin
      @(posedge sel_cpuclk);
      ok = grnt;
    end
    if (!ok)
    begin
      err_cnt++;
      $display("Timeout: request was never granted at %0t", $time);
    end
  endtask

  task automatic wait_done();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < TIMEOUT && !seen; n++)
    begin
      @(posedge sel_cpuclk);
      seen = trans_cmplt;
    end
    if (!seen)
    begin
      err_cnt++;
      $display("Timeout: transfer never completed at %0t", $time);
    end
  endtask

  task automatic run_one(input logic [31:0] addr, input logic wr, input logic sv,
                         input logic dbg, input logic deny, input logic fail);
    logic ok;
    @(posedge sel_cpuclk);
    drive_req(addr, wr, sv, dbg, deny, fail);
    wait_grant(ok);
    req      <= 1'b0;
    acc_deny <= 1'b0;
    chk_fail <= 1'b0;
    if (ok && !deny && !fail)
      wait_done();
    else
      repeat (3) @(posedge sel_cpuclk);
  endtask

  // Second request waits behind the first with req held high
  task automatic run_pair(input logic [31:0] addr_a, input logic [31:0] addr_b);
    logic ok;
    logic [31:0] r;
    r = rnd();
    @(posedge sel_cpuclk);
    drive_req(addr_a, r[0], 1'b1, 1'b0, 1'b0, 1'b0);
    wait_grant(ok);
    drive_req(addr_b, r[1], 1'b1, 1'b0, 1'b0, 1'b0);
    wait_grant(ok);
    req <= 1'b0;
    if (ok)
      wait_done();
  endtask

  task automatic end_test(input string name, input int start);
    if (err_cnt == start)
    begin
      pass_tests++;
      $display("Test %s: ok", name);
    end
    else
    begin
      fail_tests++;
      $display("Test %s: %0d errors", name, err_cnt - start);
    end
  endtask

  initial
  begin
    logic [31:0] r;
    int          start;
    wait_reset();

    start = err_cnt;
    for (int i = 0; i < 8; i++)
    begin
      r = rnd();
      run_one(any_addr(r), r[4], 1'b0, 1'b0, 1'b0, 1'b0);
    end
    end_test("privilege", start);

    start = err_cnt;
    for (int i = 0; i < 12; i++)
    begin
      r = rnd();
      run_one(mapped_addr(rnd()), r[4], r[6], !r[6] || r[7], 1'b0, 1'b0);
    end
    end_test("decode", start);

    start = err_cnt;
    for (int i = 0; i < 8; i++)
    begin
      r = rnd();
      run_one(unmapped_addr(rnd()), r[4], 1'b1, r[7], 1'b0, 1'b0);
    end
    end_test("dummy access", start);

    start = err_cnt;
    for (int i = 0; i < 6; i++)
      run_pair(mapped_addr(rnd()), any_addr(rnd()));
    end_test("back-pressure", start);

    start = err_cnt;
    for (int i = 0; i < 10; i++)
    begin
      r = rnd();
      run_one(mapped_addr(rnd()), r[4] && r[5], 1'b1, 1'b0, 1'b0, 1'b0);
    end
    end_test("read data and endian", start);

    start = err_cnt;
    for (int i = 0; i < 6; i++)
    begin
      r = rnd();
      run_one(any_addr(rnd()), r[4], r[6], r[7], r[8], !r[8] || r[9]);
    end
    end_test("suppression", start);

    repeat (4) @(posedge sel_cpuclk);
    $display("Passing tests: %0d, failing tests: %0d", pass_tests, fail_tests);
    if (fail_tests == 0 && err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
tcip_pkg.sv
tcip_priv_check.sv
tcip_addr_route.sv
tcip_resp_merge.sv
tcip_bus_if.sv
tb_clk_gen.sv
tb_tcip.sv

/* run.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_tcip -f src.f

./obj_dir/Vtb_tcip | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
